//--- logic/dcache_pkg.sv
package dcache_pkg;

    // Cache geometry
    localparam int NUM_WAYS = 2;
    localparam int NUM_SETS = 256;
    localparam int BANKS    = 4;
    localparam int WORD_W   = 32;
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;
    localparam int LINE_W   = 128;

    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    // Bits 3:2 select the bank
    typedef logic [OFFSET_W-1:0]   offset_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [WORD_W/8-1:0]   strb_t;
    // Bank 0 in the low word
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [NUM_WAYS-1:0]   way_vec_t;

    typedef struct packed {
        logic    op;
        tag_t    tag;
        index_t  index;
        offset_t offset;
        strb_t   wstrb;
        word_t   wdata;
    } cpu_req_t;

    typedef struct packed {
        index_t                            index;
        way_vec_t                          tag_we;
        way_vec_t                          bank_en;
        strb_t [NUM_WAYS-1:0][BANKS-1:0]   bank_we;
        tag_t                              tag_din;
        line_t                             bank_din;
    } ram_ctl_t;

    typedef enum logic [2:0] {IDLE, LOOKUP, WRITE, MISS, REPLACE, REFILL} state_t;

endpackage

//--- logic/dcache_ram.sv
`timescale 1ns/100ps

module dcache_ram #(
    parameter type entry_t = dcache_pkg::word_t,
    parameter int  depth   = 256
) (
    input  logic               clk,
    input  logic               en,
    input  dcache_pkg::index_t addr,
    input  entry_t             we_mask,
    input  entry_t             din,
    output entry_t             dout
);

    entry_t mem [depth];

    // Read-before-write, only bits under the mask change
    always_ff @(posedge clk) begin
        if (en) begin
            mem[addr] <= (mem[addr] & ~we_mask) | (din & we_mask);
            dout      <= mem[addr];
        end
    end

endmodule

//--- logic/dcache_meta.sv
`timescale 1ns/100ps

module dcache_meta (
    input  logic                 clk,
    input  logic                 resetn,
    input  dcache_pkg::index_t   index,
    input  logic                 fill_we,
    input  logic                 fill_way,
    input  logic                 fill_dirty,
    input  logic                 store_we,
    input  logic                 store_way,
    input  logic                 hit_we,
    input  logic                 hit_way,
    output dcache_pkg::way_vec_t valid,
    output dcache_pkg::way_vec_t dirty,
    output logic                 last_hit
);
    import dcache_pkg::*;

    way_vec_t [NUM_SETS-1:0] valid_q;
    way_vec_t [NUM_SETS-1:0] dirty_q;
    logic     [NUM_SETS-1:0] last_hit_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q    <= '0;
            dirty_q    <= '0;
            last_hit_q <= '0;
        end else begin
            // Refill installs a line, dirty if it came from a store miss
            if (fill_we) begin
                valid_q[index][fill_way] <= 1'b1;
                dirty_q[index][fill_way] <= fill_dirty;
            end
            if (store_we) begin
                dirty_q[index][store_way] <= 1'b1;
            end
            if (hit_we) begin
                last_hit_q[index] <= hit_way;
            end
        end
    end

    assign valid    = valid_q[index];
    assign dirty    = dirty_q[index];
    assign last_hit = last_hit_q[index];

endmodule

//--- logic/dcache_lookup.sv
`timescale 1ns/100ps

module dcache_lookup (
    input  dcache_pkg::cpu_req_t                          req,
    input  dcache_pkg::tag_t  [dcache_pkg::NUM_WAYS-1:0]  tag_dout,
    input  dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0]  line_dout,
    input  dcache_pkg::way_vec_t                          valid,
    input  dcache_pkg::way_vec_t                          dirty,
    input  logic                                          last_hit,
    output dcache_pkg::way_vec_t                          hit,
    output dcache_pkg::word_t                             load_word,
    output logic                                          victim,
    output dcache_pkg::tag_t                              victim_tag,
    output dcache_pkg::line_t                             victim_line,
    output logic                                          victim_dirty
);
    import dcache_pkg::*;

    logic [1:0] bank;
    logic       hit_way;

    assign bank = req.offset[3:2];

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit[w] = valid[w] && (tag_dout[w] == req.tag);
        end
    end

    assign hit_way   = hit[1];
    assign load_word = line_dout[hit_way][bank*WORD_W +: WORD_W];

    // Invalid way first, then a clean one, then away from the last hit
    always_comb begin
        if (!valid[0]) begin
            victim = 1'b0;
        end else if (!valid[1]) begin
            victim = 1'b1;
        end else if (dirty[0] != dirty[1]) begin
            victim = dirty[0];
        end else begin
            victim = !last_hit;
        end
    end

    assign victim_tag   = tag_dout[victim];
    assign victim_line  = line_dout[victim];
    assign victim_dirty = valid[victim] && dirty[victim];

endmodule

//--- logic/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 valid,
    input  dcache_pkg::cpu_req_t req_in,
    output logic                 addr_ok,
    output logic                 data_ok,
    output dcache_pkg::word_t    rdata,
    output dcache_pkg::ram_ctl_t ram,
    output dcache_pkg::cpu_req_t rb_req,
    input  dcache_pkg::way_vec_t hit,
    input  dcache_pkg::word_t    load_word,
    input  logic                 victim,
    input  dcache_pkg::tag_t     victim_tag,
    input  dcache_pkg::line_t    victim_line,
    input  logic                 victim_dirty,
    output logic                 fill_we,
    output logic                 fill_way,
    output logic                 fill_dirty,
    output logic                 store_we,
    output logic                 store_way,
    output logic                 hit_we,
    output logic                 hit_way,
    output logic                 rd_req,
    output dcache_pkg::word_t    rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  dcache_pkg::line_t    ret_data,
    output logic                 wr_req,
    output dcache_pkg::word_t    wr_addr,
    output dcache_pkg::line_t    wr_data,
    input  logic                 wr_rdy
);
    import dcache_pkg::*;

    // Store hit waiting for its bank write
    typedef struct packed {
        logic   way;
        index_t index;
        logic [1:0] bank;
        strb_t  wstrb;
        word_t  wdata;
    } wbuf_t;

    // Victim snapshot taken on a miss
    typedef struct packed {
        logic   way;
        tag_t   tag;
        line_t  line;
        logic   dirty;
    } mbuf_t;

    state_t     state;
    state_t     next_state;
    wbuf_t      wb;
    mbuf_t      mb;
    logic       accept;
    logic       lookup_hit;
    logic       lookup_miss;
    logic       refill_done;
    logic [1:0] rb_bank;
    line_t      merged;

    assign rb_bank     = rb_req.offset[3:2];
    assign lookup_hit  = (state == LOOKUP) && (|hit);
    assign lookup_miss = (state == LOOKUP) && !(|hit);
    assign refill_done = (state == REFILL) && ret_valid;

    // A store hit holds off the next request until its bank write is done
    assign addr_ok = (state == IDLE) || (lookup_hit && !rb_req.op);
    assign accept  = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!(|hit)) begin
                    next_state = MISS;
                end else if (rb_req.op) begin
                    next_state = WRITE;
                end else if (!accept) begin
                    next_state = IDLE;
                end
            end
            WRITE: next_state = IDLE;
            MISS: begin
                if (!mb.dirty || wr_rdy) begin
                    next_state = REPLACE;
                end
            end
            REPLACE: begin
                if (rd_rdy) begin
                    next_state = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rb_req <= req_in;
        end
        if (lookup_hit && rb_req.op) begin
            wb.way   <= hit[1];
            wb.index <= rb_req.index;
            wb.bank  <= rb_bank;
            wb.wstrb <= rb_req.wstrb;
            wb.wdata <= rb_req.wdata;
        end
        if (lookup_miss) begin
            mb.way   <= victim;
            mb.tag   <= victim_tag;
            mb.line  <= victim_line;
            mb.dirty <= victim_dirty;
        end
    end

    // Store miss bytes land on top of the returned line
    always_comb begin
        merged = ret_data;
        if (rb_req.op) begin
            for (int i = 0; i < WORD_W / 8; i++) begin
                if (rb_req.wstrb[i]) begin
                    merged[rb_bank*WORD_W + i*8 +: 8] = rb_req.wdata[i*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        ram       = '0;
        ram.index = req_in.index;
        if (accept) begin
            ram.bank_en = '1;
        end else if (state == WRITE) begin
            ram.index                    = wb.index;
            ram.bank_en[wb.way]          = 1'b1;
            ram.bank_we[wb.way][wb.bank] = wb.wstrb;
            ram.bank_din                 = {BANKS{wb.wdata}};
        end else if (refill_done) begin
            ram.index           = rb_req.index;
            ram.bank_en[mb.way] = 1'b1;
            ram.tag_we[mb.way]  = 1'b1;
            ram.bank_we[mb.way] = '1;
            ram.tag_din         = rb_req.tag;
            ram.bank_din        = merged;
        end
    end

    assign data_ok = lookup_hit || refill_done;
    assign rdata   = (state == REFILL) ? ret_data[rb_bank*WORD_W +: WORD_W] : load_word;

    assign fill_we    = refill_done;
    assign fill_way   = mb.way;
    assign fill_dirty = rb_req.op;
    assign store_we   = (state == WRITE);
    assign store_way  = wb.way;
    assign hit_we     = lookup_hit;
    assign hit_way    = hit[1];

    // Write-back of a dirty victim, then the line read
    assign wr_req  = (state == MISS) && mb.dirty;
    assign wr_addr = {mb.tag, rb_req.index, {OFFSET_W{1'b0}}};
    assign wr_data = mb.line;
    assign rd_req  = (state == REPLACE);
    assign rd_addr = {rb_req.tag, rb_req.index, {OFFSET_W{1'b0}}};

endmodule

//--- logic/dcache_top.sv
`timescale 1ns/100ps

module dcache_top (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 valid,
    input  dcache_pkg::cpu_req_t req,
    output logic                 addr_ok,
    output logic                 data_ok,
    output dcache_pkg::word_t    rdata,
    output logic                 rd_req,
    output dcache_pkg::word_t    rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  dcache_pkg::line_t    ret_data,
    output logic                 wr_req,
    output dcache_pkg::word_t    wr_addr,
    output dcache_pkg::line_t    wr_data,
    input  logic                 wr_rdy
);
    import dcache_pkg::*;

    ram_ctl_t                 ram;
    cpu_req_t                 rb_req;
    tag_t  [NUM_WAYS-1:0]     tag_dout;
    line_t [NUM_WAYS-1:0]     line_dout;
    way_vec_t                 way_valid;
    way_vec_t                 way_dirty;
    logic                     last_hit;
    way_vec_t                 hit;
    word_t                    load_word;
    logic                     victim;
    tag_t                     victim_tag;
    line_t                    victim_line;
    logic                     victim_dirty;
    logic                     fill_we;
    logic                     fill_way;
    logic                     fill_dirty;
    logic                     store_we;
    logic                     store_way;
    logic                     hit_we;
    logic                     hit_way;

    dcache_ctrl ctrl_i (
        .clk, .resetn, .valid, .req_in(req), .addr_ok, .data_ok, .rdata,
        .ram, .rb_req, .hit, .load_word, .victim, .victim_tag, .victim_line,
        .victim_dirty, .fill_we, .fill_way, .fill_dirty, .store_we, .store_way,
        .hit_we, .hit_way, .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy
    );

    dcache_lookup lookup_i (
        .req(rb_req), .tag_dout, .line_dout, .valid(way_valid), .dirty(way_dirty),
        .last_hit, .hit, .load_word, .victim, .victim_tag, .victim_line, .victim_dirty
    );

    dcache_meta meta_i (
        .clk, .resetn, .index(rb_req.index), .fill_we, .fill_way, .fill_dirty,
        .store_we, .store_way, .hit_we, .hit_way, .valid(way_valid),
        .dirty(way_dirty), .last_hit
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        dcache_ram #(.entry_t(tag_t), .depth(NUM_SETS)) tag_ram_i (
            .clk, .en(ram.bank_en[w]), .addr(ram.index),
            .we_mask({TAG_W{ram.tag_we[w]}}), .din(ram.tag_din), .dout(tag_dout[w])
        );

        for (genvar b = 0; b < BANKS; b++) begin : g_bank
            word_t bank_mask;

            // Byte strobes widened to a bit mask
            for (genvar k = 0; k < WORD_W / 8; k++) begin : g_byte
                assign bank_mask[k*8 +: 8] = {8{ram.bank_we[w][b][k]}};
            end

            dcache_ram #(.entry_t(word_t), .depth(NUM_SETS)) bank_ram_i (
                .clk, .en(ram.bank_en[w]), .addr(ram.index), .we_mask(bank_mask),
                .din(ram.bank_din[b*WORD_W +: WORD_W]),
                .dout(line_dout[w][b*WORD_W +: WORD_W])
            );
        end
    end

endmodule

//--- dv/dcache_asserts.sv
`timescale 1ns/100ps

module dcache_asserts (
    input logic clk,
    input logic resetn,
    input logic valid,
    input logic addr_ok,
    input logic data_ok,
    input logic rd_req,
    input logic rd_rdy,
    input logic wr_req,
    input logic wr_rdy
);

    int outstanding;

    // Accepted requests still waiting for data_ok
    always_ff @(posedge clk) begin
        if (!resetn) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(valid && addr_ok) - int'(data_ok);
        end
    end

    assert property (@(posedge clk) disable iff (!resetn) !(rd_req && wr_req))
        else $error("rd_req and wr_req high together");

    assert property (@(posedge clk) disable iff (!resetn) rd_req && !rd_rdy |=> rd_req)
        else $error("rd_req dropped before rd_rdy");

    assert property (@(posedge clk) disable iff (!resetn) wr_req && !wr_rdy |=> wr_req)
        else $error("wr_req dropped before wr_rdy");

    assert property (@(posedge clk) disable iff (!resetn) data_ok |-> outstanding != 0)
        else $error("data_ok without an accepted request");

endmodule

bind dcache_top dcache_asserts asserts_i (
    .clk(clk), .resetn(resetn), .valid(valid), .addr_ok(addr_ok), .data_ok(data_ok),
    .rd_req(rd_req), .rd_rdy(rd_rdy), .wr_req(wr_req), .wr_rdy(wr_rdy)
);

//--- dv/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;
    import dcache_pkg::*;

    // One accepted request, as the compare process sees it
    typedef struct packed {
        logic  op;
        logic  must_hit;
        int    cycle;
        word_t data;
    } exp_t;

    localparam int LIMIT = 300;

    logic     clk;
    logic     resetn;
    logic     valid;
    cpu_req_t req;
    logic     addr_ok;
    logic     data_ok;
    word_t    rdata;
    logic     rd_req;
    word_t    rd_addr;
    logic     rd_rdy;
    logic     ret_valid;
    line_t    ret_data;
    logic     wr_req;
    word_t    wr_addr;
    line_t    wr_data;
    logic     wr_rdy;
    logic     expect_hit;
    logic     timed_out = 1'b0;

    integer   seed = 5;
    int       errors = 0;
    int       accepted = 0;
    int       cycle_count = 0;
    word_t    last_line = '0;
    exp_t     exp_q [$];
    word_t    golden [word_t];
    line_t    mem_lines [word_t];

    dcache_top dut_i (
        .clk, .resetn, .valid, .req, .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy
    );

    always #5 clk = ~clk;

    function automatic word_t next_random();
        return $random(seed);
    endfunction

    // Contents of a word that was never written
    function automatic word_t fill_word(input word_t a);
        return (a * 32'h0001_0003) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic word_t golden_word(input word_t a);
        return golden.exists(a) ? golden[a] : fill_word(a);
    endfunction

    function automatic line_t golden_line(input word_t a);
        line_t l;
        for (int b = 0; b < BANKS; b++) begin
            l[b*WORD_W +: WORD_W] = golden_word(a + 32'(4 * b));
        end
        return l;
    endfunction

    function automatic line_t memory_line(input word_t a);
        line_t l;
        for (int b = 0; b < BANKS; b++) begin
            l[b*WORD_W +: WORD_W] = fill_word(a + 32'(4 * b));
        end
        if (mem_lines.exists(a)) begin
            l = mem_lines[a];
        end
        return l;
    endfunction

    // Stores update the flat memory, every access returns the word after it
    function automatic word_t ref_access(input cpu_req_t r);
        word_t a;
        word_t w;
        a = {r.tag, r.index, r.offset[3:2], 2'b00};
        w = golden_word(a);
        for (int i = 0; i < WORD_W / 8; i++) begin
            if (r.op && r.wstrb[i]) begin
                w[i*8 +: 8] = r.wdata[i*8 +: 8];
            end
        end
        if (r.op) begin
            golden[a] = w;
        end
        return w;
    endfunction

    task automatic report_timeout(input string msg);
        errors++;
        timed_out = 1'b1;
        $display("Timeout: %s", msg);
    endtask

    task automatic issue(input logic op, input word_t addr, input strb_t strb,
                         input word_t data, input logic must_hit);
        int t;
        if (!timed_out) begin
            valid      = 1'b1;
            req        = {op, addr, strb, data};
            expect_hit = must_hit;
            t = 0;
            @(negedge clk);
            while (!addr_ok && t < LIMIT) begin
                @(negedge clk);
                t++;
            end
            if (!addr_ok) begin
                report_timeout("request never accepted");
            end else begin
                @(posedge clk);
                #1;
                valid = 1'b0;
            end
        end
    endtask

    task automatic wait_done();
        int t;
        t = 0;
        while (!timed_out && exp_q.size() != 0 && t < LIMIT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (!timed_out && exp_q.size() != 0) begin
            report_timeout("data_ok missing for an accepted request");
        end
    endtask

    // Memory side, sampled at the falling edge and driven after the rising one
    initial begin : mem_model
        word_t rd_line;
        word_t rnd;
        int    delay;
        logic  pending;
        pending   = 1'b0;
        delay     = 0;
        rd_line   = '0;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk);
            rnd = next_random();
            if (wr_req && wr_rdy) begin
                assert (wr_data == golden_line(wr_addr)) else begin
                    errors++;
                    $display("FAILED wr_data: got %h expected %h",
                             wr_data, golden_line(wr_addr));
                end
                mem_lines[wr_addr] = wr_data;
            end
            if (rd_req && rd_rdy) begin
                // Refill fetches the line of the request that missed
                assert (rd_addr == last_line) else begin
                    errors++;
                    $display("FAILED rd_addr: got %h expected %h", rd_addr, last_line);
                end
                pending = 1'b1;
                rd_line = rd_addr;
                delay   = 1 + int'(rnd[3:2]);
            end
            @(posedge clk);
            #1;
            ret_valid = 1'b0;
            if (pending) begin
                delay--;
                if (delay == 0) begin
                    ret_valid = 1'b1;
                    ret_data  = memory_line(rd_line);
                    pending   = 1'b0;
                end
            end
            rd_rdy = rnd[0];
            wr_rdy = rnd[1];
        end
    end

    always @(negedge clk) begin : compare
        exp_t e;
        if (resetn) begin
            cycle_count++;
            if (accepted == 0) begin
                assert (!data_ok && !rd_req && !wr_req) else begin
                    errors++;
                    $display("Output active before the first request was accepted");
                end
            end
            if (data_ok) begin
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("data_ok without an outstanding request");
                end
                if (exp_q.size() != 0) begin
                    e = exp_q.pop_front();
                    if (!e.op) begin
                        assert (rdata == e.data) else begin
                            errors++;
                            $display("FAILED rdata: got %h expected %h", rdata, e.data);
                        end
                    end
                    if (e.must_hit) begin
                        assert (cycle_count == e.cycle + 1) else begin
                            errors++;
                            $display("Hit did not answer one cycle after acceptance");
                        end
                    end
                end
            end
            if (valid && addr_ok) begin
                e.op       = req.op;
                e.must_hit = expect_hit;
                e.cycle    = cycle_count;
                e.data     = ref_access(req);
                exp_q.push_back(e);
                last_line = {req.tag, req.index, 4'h0};
                accepted++;
            end
        end
    end

    initial begin : stimulus
        word_t a;
        word_t r;
        clk        = 1'b0;
        resetn     = 1'b0;
        valid      = 1'b0;
        req        = '0;
        expect_hit = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;
        repeat (4) @(posedge clk);
        #1;

        // Cold miss, then a hit on the same line
        issue(1'b0, 32'h0000_1230, 4'h0, 32'h0, 1'b0);
        wait_done();
        issue(1'b0, 32'h0000_1234, 4'h0, 32'h0, 1'b1);
        issue(1'b1, 32'h0000_1238, 4'b0101, 32'hdead_beef, 1'b1);
        issue(1'b0, 32'h0000_1238, 4'h0, 32'h0, 1'b1);

        // Partial store that misses
        issue(1'b1, 32'h0000_4564, 4'b0110, 32'hcafe_f00d, 1'b0);
        issue(1'b0, 32'h0000_4564, 4'h0, 32'h0, 1'b1);

        // Three tags in one set, the third evicts a dirty line
        for (int i = 1; i <= 3; i++) begin
            issue(1'b1, {20'(i), 8'h10, 4'h4}, 4'hf, next_random(), 1'b0);
        end
        for (int i = 1; i <= 3; i++) begin
            issue(1'b0, {20'(i), 8'h10, 4'h4}, 4'h0, 32'h0, 1'b0);
        end

        repeat (400) begin
            r = next_random();
            a = {20'h00100 + 20'(r[1:0]), 8'h20 + 8'(r[3:2]), r[5:4], 2'b00};
            issue(r[6], a, r[10:7], next_random(), 1'b0);
        end
        wait_done();

        $display("Requests: %0d, errors: %0d", accepted, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- dcache_top.f
logic/dcache_pkg.sv
logic/dcache_ram.sv
logic/dcache_meta.sv
logic/dcache_lookup.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
dv/dcache_asserts.sv
dv/dcache_tb.sv

//--- Makefile
TOP = dcache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f dcache_top.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: compile
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf obj_dir
